// File: logic/conv_geom_pkg.sv
package conv_geom_pkg;

   // ------------------------------
   // Frame size
   // ------------------------------
   localparam int IMG_WIDTH    = 8;                      // Columns per row
   localparam int IMG_HEIGHT   = 6;                      // Rows per frame
   localparam int FRAME_PIXELS = IMG_WIDTH * IMG_HEIGHT; // 48 pixels

   // Sync periods, in clock cycles
   localparam int VSYNC_CYCLES = 16;                     // Start period
   localparam int HSYNC_CYCLES = 4;                      // Gap before each row

   localparam int ROW_W        = 3;                      // Row index
   localparam int COL_W        = 3;                      // Column index
   localparam int PIX_ADDR_W   = 6;                      // Pixel index within a frame
   localparam int CNT_W        = 5;                      // Sync counter

endpackage

// File: logic/conv_arith_pkg.sv
package conv_arith_pkg;

   // ------------------------------
   // Channels and taps
   // ------------------------------
   localparam int N_IN_CH    = 3;          // Input channels
   localparam int N_TAPS     = 27;         // 3x3 window times N_IN_CH
   localparam int N_KERNELS  = 8;          // Output channels

   localparam int ACT_W      = 8;          // Unsigned activation
   localparam int WGT_W      = 8;          // Two's complement weight
   localparam int ACC_W      = 21;         // Signed sum of 27 products

   // Result byte taken from the sum
   localparam int OUT_MSB    = 20;
   localparam int OUT_LSB    = 13;

   localparam int KADDR_W    = 3;          // Kernel index
   localparam int IMG_ADDR_W = 8;          // 144-byte image buffer

endpackage

// File: logic/frame_ctrl.sv
module frame_ctrl (
   input  logic                            clk,
   input  logic                            rstn,
   input  logic                            i_start,      // Pulse, ignored while busy
   output logic                            o_busy,
   output logic                            o_vsync_run,
   output logic [conv_geom_pkg::CNT_W-1:0] o_vsync_cnt,
   output logic                            o_data_run,
   output logic [conv_geom_pkg::ROW_W-1:0] o_row,
   output logic [conv_geom_pkg::COL_W-1:0] o_col,
   output logic                            o_end_frame   // One cycle after last data
);
   import conv_geom_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_VSYNC,
      ST_HSYNC,
      ST_DATA
   } state_t;

   state_t           state;
   logic [CNT_W-1:0] cnt;                                 // Shared by vsync and hsync

   // ------------------------------
   // Frame sequencing
   // ------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state       <= ST_IDLE;
         cnt         <= '0;
         o_row       <= '0;
         o_col       <= '0;
         o_end_frame <= 1'b0;
      end else begin
         o_end_frame <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (i_start) begin
                  state <= ST_VSYNC;
                  cnt   <= '0;                            // Count 0 on first vsync cycle
               end
            end
            ST_VSYNC: begin
               if (cnt == CNT_W'(VSYNC_CYCLES - 1)) begin
                  state <= ST_HSYNC;
                  cnt   <= '0;
                  o_row <= '0;                            // Frame starts at row 0
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_HSYNC: begin
               if (cnt == CNT_W'(HSYNC_CYCLES - 1)) begin
                  state <= ST_DATA;
                  o_col <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            ST_DATA: begin
               if (o_col == COL_W'(IMG_WIDTH - 1)) begin  // End of row
                  o_col <= '0;
                  cnt   <= '0;
                  if (o_row == ROW_W'(IMG_HEIGHT - 1)) begin
                     state       <= ST_IDLE;
                     o_end_frame <= 1'b1;                 // Last pixel issued
                  end else begin
                     state <= ST_HSYNC;
                     o_row <= o_row + 1'b1;
                  end
               end else begin
                  o_col <= o_col + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign o_busy      = (state != ST_IDLE);
   assign o_vsync_run = (state == ST_VSYNC);
   assign o_vsync_cnt = cnt;                              // Only meaningful in vsync
   assign o_data_run  = (state == ST_DATA);

   // Data cycles never leave the frame
   a_data_in_frame: assert property (@(posedge clk) disable iff (!rstn)
      o_data_run |-> (int'(o_col) < IMG_WIDTH) && (int'(o_row) < IMG_HEIGHT));

endmodule

// File: logic/window_gen.sv
module window_gen (
   input  logic                                                   clk,
   input  logic                                                   rstn,
   input  logic                                                   i_busy,
   input  logic                                                   i_img_we,
   input  logic [conv_arith_pkg::IMG_ADDR_W-1:0]                  i_img_addr,
   input  logic [conv_arith_pkg::ACT_W-1:0]                       i_img_data,
   input  logic                                                   i_data_run,
   input  logic [conv_geom_pkg::ROW_W-1:0]                        i_row,
   input  logic [conv_geom_pkg::COL_W-1:0]                        i_col,
   output logic [conv_arith_pkg::N_TAPS*conv_arith_pkg::ACT_W-1:0] o_win,
   output logic                                                   o_win_vld
);
   import conv_geom_pkg::*;
   import conv_arith_pkg::*;

   logic [ACT_W-1:0]        img_mem [0:N_IN_CH*FRAME_PIXELS-1]; // Channel-major planes
   logic [N_TAPS*ACT_W-1:0] win_next;

   // ------------------------------
   // Image buffer write port
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_img_we) begin
         img_mem[i_img_addr] <= i_img_data;
      end
   end

   // Tap t = ch*9 + (dr+1)*3 + (dc+1), tap 0 in the low byte
   always_comb begin : tap_sel
      int r;
      int c;
      int t;
      win_next = '0;                                   // Padding is zero
      t        = 0;
      for (int ch = 0; ch < N_IN_CH; ch++) begin
         for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
               r = int'(i_row) + dr;
               c = int'(i_col) + dc;
               if (r >= 0 && r < IMG_HEIGHT && c >= 0 && c < IMG_WIDTH) begin
                  win_next[t*ACT_W +: ACT_W] = img_mem[ch*FRAME_PIXELS + r*IMG_WIDTH + c];
               end
               t++;
            end
         end
      end
   end

   // ------------------------------
   // Window register
   // ------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_win_vld <= 1'b0;
      end else begin
         o_win_vld <= i_data_run;                      // One cycle after data cycle
      end
   end

   always_ff @(posedge clk) begin
      if (i_data_run) begin
         o_win <= win_next;
      end
   end

   // Image may only change between frames
   a_img_wr_idle: assert property (@(posedge clk) disable iff (!rstn)
      i_img_we |-> !i_busy && (int'(i_img_addr) < N_IN_CH*FRAME_PIXELS));

endmodule

// File: logic/weight_loader.sv
module weight_loader (
   input  logic                                      clk,
   input  logic                                      rstn,
   input  logic                                      i_busy,
   input  logic                                      i_wt_we,
   input  logic [conv_arith_pkg::KADDR_W-1:0]        i_wt_kernel,
   input  logic [$clog2(conv_arith_pkg::N_TAPS)-1:0] i_wt_tap,
   input  logic [conv_arith_pkg::WGT_W-1:0]          i_wt_data,
   input  logic                                      i_vsync_run,
   input  logic [conv_geom_pkg::CNT_W-1:0]           i_vsync_cnt,
   output logic [conv_arith_pkg::N_KERNELS-1:0]
                [conv_arith_pkg::N_TAPS*conv_arith_pkg::WGT_W-1:0] o_weights
);
   import conv_arith_pkg::*;

   logic [N_TAPS*WGT_W-1:0] wt_mem [0:N_KERNELS-1];   // One word per kernel
   logic                    rd_en;
   logic [KADDR_W-1:0]      rd_addr;
   logic [N_TAPS*WGT_W-1:0] rd_data;                  // Registered read word
   logic                    rd_en_d;
   logic [KADDR_W-1:0]      rd_addr_d;

   // ------------------------------
   // Weight store
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_wt_we) begin
         wt_mem[i_wt_kernel][i_wt_tap*WGT_W +: WGT_W] <= i_wt_data; // Byte write
      end
   end

   // First N_KERNELS vsync counts read one word each
   assign rd_en   = i_vsync_run && (int'(i_vsync_cnt) < N_KERNELS);
   assign rd_addr = i_vsync_cnt[KADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= wt_mem[rd_addr];
      end
   end

   // ------------------------------
   // Steer read word to its kernel
   // ------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         rd_en_d   <= 1'b0;
         rd_addr_d <= '0;
      end else begin
         rd_en_d   <= rd_en;                          // Aligns with rd_data
         rd_addr_d <= rd_addr;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         o_weights <= '0;
      end else if (rd_en_d) begin
         o_weights[rd_addr_d] <= rd_data;             // Two cycles after the count
      end
   end

   // Store is only written between frames
   a_wt_wr_idle: assert property (@(posedge clk) disable iff (!rstn)
      i_wt_we |-> !i_busy && (int'(i_wt_tap) < N_TAPS));

endmodule

// File: logic/conv_kernel.sv
module conv_kernel (
   input  logic                                                   clk,
   input  logic                                                   rstn,
   input  logic                                                   i_vld,
   input  logic [conv_arith_pkg::N_TAPS*conv_arith_pkg::ACT_W-1:0] i_win,
   input  logic [conv_arith_pkg::N_TAPS*conv_arith_pkg::WGT_W-1:0] i_weights,
   output logic [conv_arith_pkg::ACT_W-1:0]                       o_result,
   output logic                                                   o_vld
);
   import conv_arith_pkg::*;

   logic signed [ACT_W+WGT_W:0] prod [0:N_TAPS-1];    // 9b x 8b signed products
   logic                        vld_d;
   logic signed [ACC_W-1:0]     sum_comb;
   logic signed [ACC_W-1:0]     sum_q;

   // ------------------------------
   // Stage 1, products
   // ------------------------------
   always_ff @(posedge clk) begin
      if (i_vld) begin
         for (int t = 0; t < N_TAPS; t++) begin
            prod[t] <= $signed({1'b0, i_win[t*ACT_W +: ACT_W]})     // Zero-extended pixel
                     * $signed(i_weights[t*WGT_W +: WGT_W]);
         end
      end
   end

   // Adder tree, sign extended to ACC_W
   always_comb begin
      sum_comb = '0;
      for (int t = 0; t < N_TAPS; t++) begin
         sum_comb = sum_comb + prod[t];
      end
   end

   // Stage 2, sum
   always_ff @(posedge clk) begin
      if (vld_d) begin
         sum_q <= sum_comb;
      end
   end

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         vld_d <= 1'b0;
         o_vld <= 1'b0;
      end else begin
         vld_d <= i_vld;
         o_vld <= vld_d;                               // Two cycles behind i_vld
      end
   end

   assign o_result = sum_q[OUT_MSB:OUT_LSB];           // Top byte of the sum

endmodule

// File: logic/output_collector.sv
module output_collector (
   input  logic                                                      clk,
   input  logic                                                      rstn,
   input  logic                                                      i_start,
   input  logic                                                      i_vld,   // Kernel 0
   input  logic [conv_arith_pkg::N_KERNELS-1:0][conv_arith_pkg::ACT_W-1:0] i_results,
   output logic                                                      o_pix_vld,
   output logic [conv_geom_pkg::PIX_ADDR_W-1:0]                      o_pix_addr,
   output logic [conv_arith_pkg::N_KERNELS*conv_arith_pkg::ACT_W-1:0] o_pix_data,
   output logic                                                      o_layer_done
);
   import conv_geom_pkg::*;

   logic [PIX_ADDR_W-1:0] pix_cnt;                     // Index of next strobed pixel
   logic                  done_q;
   logic                  last_pix;
   logic                  start_ok;

   assign last_pix = i_vld && (pix_cnt == PIX_ADDR_W'(FRAME_PIXELS - 1));
   assign start_ok = i_start && (pix_cnt == '0);       // Mid-frame start ignored

   // ------------------------------
   // Pixel counter and done flag
   // ------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         pix_cnt <= '0;
         done_q  <= 1'b0;
      end else if (i_vld) begin
         pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;    // Wraps after last pixel
         done_q  <= done_q || last_pix;
      end else if (start_ok) begin
         pix_cnt <= '0;
         done_q  <= 1'b0;
      end
   end

   assign o_pix_vld    = i_vld;
   assign o_pix_addr   = pix_cnt;
   assign o_pix_data   = i_results;                    // Kernel k in byte k
   assign o_layer_done = done_q || last_pix;           // Rises with last strobe

   // No stray pixels once the layer has finished
   a_no_vld_after_done: assert property (@(posedge clk) disable iff (!rstn)
      done_q |-> !i_vld);

endmodule

// File: logic/conv_layer_top.sv
module conv_layer_top (
   input  logic                                                      clk,
   input  logic                                                      rstn,
   input  logic                                                      i_start,
   input  logic                                                      i_img_we,
   input  logic [conv_arith_pkg::IMG_ADDR_W-1:0]                     i_img_addr,
   input  logic [conv_arith_pkg::ACT_W-1:0]                          i_img_data,
   input  logic                                                      i_wt_we,
   input  logic [conv_arith_pkg::KADDR_W-1:0]                        i_wt_kernel,
   input  logic [$clog2(conv_arith_pkg::N_TAPS)-1:0]                 i_wt_tap,
   input  logic [conv_arith_pkg::WGT_W-1:0]                          i_wt_data,
   output logic                                                      o_busy,
   output logic                                                      o_pix_vld,
   output logic [conv_geom_pkg::PIX_ADDR_W-1:0]                      o_pix_addr,
   output logic [conv_arith_pkg::N_KERNELS*conv_arith_pkg::ACT_W-1:0] o_pix_data,
   output logic                                                      o_layer_done
);
   import conv_geom_pkg::*;
   import conv_arith_pkg::*;

   logic                                       vsync_run;
   logic [CNT_W-1:0]                           vsync_cnt;
   logic                                       data_run;
   logic [ROW_W-1:0]                           row;
   logic [COL_W-1:0]                           col;
   logic [N_TAPS*ACT_W-1:0]                    win;      // Shared by all kernels
   logic                                       win_vld;
   logic [N_KERNELS-1:0][N_TAPS*WGT_W-1:0]     weights;
   logic [N_KERNELS-1:0][ACT_W-1:0]            results;
   logic [N_KERNELS-1:0]                       kern_vld; // Identical, bit 0 used

   // ------------------------------
   // Control and data feed
   // ------------------------------
   frame_ctrl frame_ctrl_inst (
      .clk         (clk),
      .rstn        (rstn),
      .i_start     (i_start),
      .o_busy      (o_busy),
      .o_vsync_run (vsync_run),
      .o_vsync_cnt (vsync_cnt),
      .o_data_run  (data_run),
      .o_row       (row),
      .o_col       (col),
      .o_end_frame ()                                     // Frame end not needed here
   );

   window_gen window_gen_inst (
      .clk        (clk),
      .rstn       (rstn),
      .i_busy     (o_busy),
      .i_img_we   (i_img_we),
      .i_img_addr (i_img_addr),
      .i_img_data (i_img_data),
      .i_data_run (data_run),
      .i_row      (row),
      .i_col      (col),
      .o_win      (win),
      .o_win_vld  (win_vld)
   );

   weight_loader weight_loader_inst (
      .clk         (clk),
      .rstn        (rstn),
      .i_busy      (o_busy),
      .i_wt_we     (i_wt_we),
      .i_wt_kernel (i_wt_kernel),
      .i_wt_tap    (i_wt_tap),
      .i_wt_data   (i_wt_data),
      .i_vsync_run (vsync_run),
      .i_vsync_cnt (vsync_cnt),
      .o_weights   (weights)
   );

   // ------------------------------
   // Kernel array
   // ------------------------------
   for (genvar k = 0; k < N_KERNELS; k++) begin : g_kernel
      conv_kernel conv_kernel_inst (
         .clk       (clk),
         .rstn      (rstn),
         .i_vld     (win_vld),
         .i_win     (win),
         .i_weights (weights[k]),
         .o_result  (results[k]),
         .o_vld     (kern_vld[k])
      );
   end

   output_collector output_collector_inst (
      .clk          (clk),
      .rstn         (rstn),
      .i_start      (i_start),
      .i_vld        (kern_vld[0]),
      .i_results    (results),
      .o_pix_vld    (o_pix_vld),
      .o_pix_addr   (o_pix_addr),
      .o_pix_data   (o_pix_data),
      .o_layer_done (o_layer_done)
   );

endmodule

// File: testbench/tb_conv_layer.sv
module tb_conv_layer;
   timeunit 1ns;
   timeprecision 1ps;
   import conv_geom_pkg::*;
   import conv_arith_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int TAP_W        = $clog2(N_TAPS);
   localparam int FRAME_CYCLES = VSYNC_CYCLES + IMG_HEIGHT * (HSYNC_CYCLES + IMG_WIDTH);
   localparam int LOAD_CYCLES  = N_IN_CH * FRAME_PIXELS + 2 * N_KERNELS * N_TAPS;
   localparam int WATCHDOG_NS  = 2 * (3 * FRAME_CYCLES + LOAD_CYCLES) * CLK_PERIOD;

   logic                          clk;
   logic                          rstn;
   logic                          i_start;
   logic                          i_img_we;
   logic [IMG_ADDR_W-1:0]         i_img_addr;
   logic [ACT_W-1:0]              i_img_data;
   logic                          i_wt_we;
   logic [KADDR_W-1:0]            i_wt_kernel;
   logic [TAP_W-1:0]              i_wt_tap;
   logic [WGT_W-1:0]              i_wt_data;
   logic                          o_busy;
   logic                          o_pix_vld;
   logic [PIX_ADDR_W-1:0]         o_pix_addr;
   logic [N_KERNELS*ACT_W-1:0]    o_pix_data;
   logic                          o_layer_done;

   int                            img_ref [0:N_IN_CH*FRAME_PIXELS-1];  // Model image
   int                            wt_ref [0:N_KERNELS-1][0:N_TAPS-1]; // Model weights
   logic [31:0]                   rng;
   int                            errors;
   int                            exp_addr;                 // Next expected pixel
   int                            frame_strobes;            // Since accepted start
   int                            total_strobes;
   int                            busy_left;                // Frame cycles still to run
   logic                          first_start_seen;
   logic [N_KERNELS*ACT_W-1:0]    exp_data;

   conv_layer_top conv_layer_top_inst (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Zero-padded 3x3x3 sum for kernel k, result is bits 20..13
   function automatic logic [ACT_W-1:0] model_byte(input int k, input int pix);
      int          r;
      int          c;
      int          sum;
      logic [31:0] s;
      sum = 0;
      for (int ch = 0; ch < N_IN_CH; ch++) begin
         for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
               r = pix / IMG_WIDTH + dr;
               c = pix % IMG_WIDTH + dc;
               if (r >= 0 && r < IMG_HEIGHT && c >= 0 && c < IMG_WIDTH) begin
                  sum += img_ref[ch*FRAME_PIXELS + r*IMG_WIDTH + c]
                         * wt_ref[k][ch*9 + (dr+1)*3 + (dc+1)];
               end
            end
         end
      end
      s = sum;
      return s[OUT_MSB:OUT_LSB];
   endfunction

   always_comb begin
      for (int k = 0; k < N_KERNELS; k++) begin
         exp_data[k*ACT_W +: ACT_W] = model_byte(k, exp_addr);
      end
   end

   // ------------------------------
   // Expected raster position
   // ------------------------------
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         exp_addr      <= 0;
         frame_strobes <= 0;
         total_strobes <= 0;
         busy_left     <= 0;
      end else begin
         if (o_pix_vld) begin
            exp_addr      <= (exp_addr == FRAME_PIXELS - 1) ? 0 : exp_addr + 1;
            total_strobes <= total_strobes + 1;
         end
         if (busy_left != 0) busy_left <= busy_left - 1;        // Start ignored here
         else if (i_start) busy_left <= FRAME_CYCLES;
         if (i_start && busy_left == 0) frame_strobes <= 0;     // Accepted start only
         else if (o_pix_vld) frame_strobes <= frame_strobes + 1;
      end
   end

   // ------------------------------
   // Checks
   // ------------------------------
   a_idle_after_reset: assert property (@(posedge clk) disable iff (!rstn)
      !first_start_seen |-> !o_busy && !o_pix_vld && !o_layer_done)
      else begin
         errors++;
         $display("At %0t ns the DUT left idle before any start", $time);
      end

   a_busy: assert property (@(posedge clk) disable iff (!rstn)
      o_busy == (busy_left != 0))
      else begin
         errors++;
         $display("Mismatch at %0t ns: o_busy expected %0b got %0b",
                  $time, $sampled(busy_left) != 0, $sampled(o_busy));
      end

   a_pix_addr: assert property (@(posedge clk) disable iff (!rstn)
      o_pix_vld |-> int'(o_pix_addr) == exp_addr)
      else begin
         errors++;
         $display("Mismatch at %0t ns: o_pix_addr expected %0d got %0d",
                  $time, $sampled(exp_addr), $sampled(o_pix_addr));
      end

   for (genvar k = 0; k < N_KERNELS; k++) begin : g_byte_chk
      a_pix_byte: assert property (@(posedge clk) disable iff (!rstn)
         o_pix_vld |-> o_pix_data[k*ACT_W +: ACT_W] == exp_data[k*ACT_W +: ACT_W])
         else begin
            errors++;
            $display("Mismatch at %0t ns: o_pix_data byte %0d expected %02h got %02h",
                     $time, k, $sampled(exp_data[k*ACT_W +: ACT_W]),
                     $sampled(o_pix_data[k*ACT_W +: ACT_W]));
         end
   end

   a_done_with_last: assert property (@(posedge clk) disable iff (!rstn)
      o_pix_vld |-> o_layer_done == (exp_addr == FRAME_PIXELS - 1))
      else begin
         errors++;
         $display("Mismatch at %0t ns: o_layer_done expected %0b got %0b",
                  $time, $sampled(exp_addr) == FRAME_PIXELS - 1, $sampled(o_layer_done));
      end

   a_done_rise: assert property (@(posedge clk) disable iff (!rstn)
      $rose(o_layer_done) |-> o_pix_vld)
      else begin
         errors++;
         $display("At %0t ns o_layer_done rose without a pixel strobe", $time);
      end

   a_frame_count: assert property (@(posedge clk) disable iff (!rstn)
      o_pix_vld && exp_addr == FRAME_PIXELS - 1 |-> frame_strobes == FRAME_PIXELS - 1)
      else begin
         errors++;
         $display("Mismatch at %0t ns: strobes per frame expected %0d got %0d",
                  $time, FRAME_PIXELS, $sampled(frame_strobes) + 1);
      end

   a_no_stray: assert property (@(posedge clk) disable iff (!rstn)
      o_layer_done && !o_pix_vld |=> !o_pix_vld)
      else begin
         errors++;
         $display("At %0t ns a pixel strobe came while the layer was done", $time);
      end

   a_start_clears: assert property (@(posedge clk) disable iff (!rstn)
      i_start && busy_left == 0 && o_layer_done |=> !o_layer_done)
      else begin
         errors++;
         $display("At %0t ns a new start did not clear o_layer_done", $time);
      end

   // ------------------------------
   // Stimulus
   // ------------------------------
   task automatic load_image();
      for (int a = 0; a < N_IN_CH * FRAME_PIXELS; a++) begin
         @(negedge clk);
         rng        = xorshift32(rng);
         i_img_we   = 1'b1;
         i_img_addr = IMG_ADDR_W'(a);
         i_img_data = rng[7:0];
         img_ref[a] = int'(rng[7:0]);                       // Unsigned pixel
      end
      @(negedge clk);
      i_img_we = 1'b0;
   endtask

   task automatic load_weights();
      int val;
      for (int k = 0; k < N_KERNELS; k++) begin
         for (int t = 0; t < N_TAPS; t++) begin
            @(negedge clk);
            rng         = xorshift32(rng);
            val         = int'(rng[6:0]) - 48;              // Range -48..79
            i_wt_we     = 1'b1;
            i_wt_kernel = KADDR_W'(k);
            i_wt_tap    = TAP_W'(t);
            i_wt_data   = WGT_W'(val);
            wt_ref[k][t] = val;
         end
      end
      @(negedge clk);
      i_wt_we = 1'b0;
   endtask

   task automatic pulse_start();
      @(negedge clk);
      i_start          = 1'b1;
      first_start_seen = 1'b1;
      @(negedge clk);
      i_start = 1'b0;
   endtask

   task automatic wait_layer_done();
      while (!o_layer_done) @(negedge clk);                 // Watchdog bounds this
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      rstn             = 1'b0;
      i_start          = 1'b0;
      i_img_we         = 1'b0;
      i_img_addr       = '0;
      i_img_data       = '0;
      i_wt_we          = 1'b0;
      i_wt_kernel      = '0;
      i_wt_tap         = '0;
      i_wt_data        = '0;
      errors           = 0;
      first_start_seen = 1'b0;
      rng              = 32'hf932;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      repeat (4) @(negedge clk);                            // Idle window after reset
      load_image();
      load_weights();
      pulse_start();                                        // Frame 1
      wait_layer_done();
      load_weights();                                       // New weights for frame 2
      pulse_start();
      while (frame_strobes < 20) @(negedge clk);
      pulse_start();                                        // Busy, must be ignored
      wait_layer_done();
      pulse_start();                                        // Frame 3 clears done
      wait_layer_done();
      repeat (4) @(negedge clk);
      if (total_strobes != 3 * FRAME_PIXELS) begin
         errors++;
         $display("Mismatch at %0t ns: total_strobes expected %0d got %0d",
                  $time, 3 * FRAME_PIXELS, total_strobes);
      end
      $display("Checks done: %0d errors, %0d pixel strobes", errors, total_strobes);
      if (errors == 0) $display("TEST OK");
      else $display("TEST FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
      $display("TEST FAILED");
      $finish;
   end

endmodule

// File: build.f
logic/conv_geom_pkg.sv
logic/conv_arith_pkg.sv
logic/frame_ctrl.sv
logic/window_gen.sv
logic/weight_loader.sv
logic/conv_kernel.sv
logic/output_collector.sv
logic/conv_layer_top.sv
testbench/tb_conv_layer.sv

// File: Makefile
SRCS = $(wildcard logic/*.sv testbench/*.sv)
BIN  = obj_dir/Vtb_conv_layer

.PHONY: all run clean

all: $(BIN)

$(BIN): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_layer -f build.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir
